// ==== all.f ====
hdl/dispatch_pkg.sv
hdl/queued_count.sv
hdl/entry_ring.sv
hdl/flush_timer.sv
hdl/fetch_ctrl.sv
hdl/dispatch_top.sv
verif/tb_dispatch.sv

// ==== hdl/dispatch_pkg.sv ====
/* shared widths, sizes, slot and bundle structs, wishbone structs
   and the fetch state encoding for the dispatch stage */
package dispatch_pkg;

    // ========================================
    // sizes
    // ========================================
    // slots per fetched bundle
    localparam int slots = 4;
    // most slots queued in one cycle
    localparam int ways = 3;
    localparam int iq_entries = 8;
    localparam int rob_entries = 16;
    // recovery window after a branch miss, in cycles
    localparam int flush_cycles = 4;
    localparam int flush_w = $clog2(flush_cycles + 1);

    // ========================================
    // plain vector types
    // ========================================
    // bundle address, counted in bundle words
    typedef logic [15:0] adr_t;
    // queued slot count, 0..4
    typedef logic [2:0] cnt_t;
    // one bit per slot
    typedef logic [slots-1:0] slot_mask_t;
    // free counts, one bit wider so a full-empty ring fits
    typedef logic [$clog2(iq_entries):0] iq_free_t;
    typedef logic [$clog2(rob_entries):0] rob_free_t;
    typedef logic [flush_w-1:0] flush_cnt_t;

    // ========================================
    // bundle and bus structs
    // ========================================
    // one byte per slot, valid in the top bit
    typedef struct packed {
        logic       valid;
        logic       brk;
        logic       jc;
        logic       ret;
        logic       take_branch;
        logic [2:0] tag;
    } slot_t;

    // slot 0 sits in the low byte of the bus word
    typedef struct packed {
        slot_t [slots-1:0] slot;
    } bundle_t;

    // master side of the wishbone classic read
    typedef struct packed {
        logic cyc;
        logic stb;
        adr_t adr;
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        idle,
        fetch,
        dispatch,
        flush
    } fetch_state_t;

endpackage

// ==== hdl/dispatch_top.sv ====
/* dispatch stage top: fetch FSM, flush timer, queue count,
   issue queue and reorder buffer rings */
`timescale 1ns/1ns

module dispatch_top (
    input  logic                     clk,
    input  logic                     rst,
    output dispatch_pkg::wb_req_t    wb_req,
    input  dispatch_pkg::wb_rsp_t    wb_rsp,
    input  logic                     branch_miss,
    input  dispatch_pkg::adr_t       redirect_adr,
    input  logic                     iq_release,
    input  logic                     rob_release,
    input  logic                     debug_on,
    output dispatch_pkg::cnt_t       dispatch_cnt,
    output dispatch_pkg::slot_mask_t dispatch_onp
);

    logic hold;
    logic flush;
    logic timer_start;
    logic timer_done;
    dispatch_pkg::slot_mask_t slot_v;
    dispatch_pkg::slot_mask_t slot_brk;
    dispatch_pkg::slot_mask_t slot_jc;
    dispatch_pkg::slot_mask_t slot_ret;
    dispatch_pkg::slot_mask_t slot_tb;
    dispatch_pkg::iq_free_t iq_free;
    dispatch_pkg::rob_free_t rob_free;

    // ========================================
    // fetch and recovery
    // ========================================
    fetch_ctrl u_fetch (
        .clk          (clk),
        .rst          (rst),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .branch_miss  (branch_miss),
        .redirect_adr (redirect_adr),
        .queued_onp   (dispatch_onp),
        .timer_done   (timer_done),
        .hold         (hold),
        .flush        (flush),
        .timer_start  (timer_start),
        .slot_v       (slot_v),
        .slot_brk     (slot_brk),
        .slot_jc      (slot_jc),
        .slot_ret     (slot_ret),
        .slot_tb      (slot_tb)
    );

    flush_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .start (timer_start),
        .done  (timer_done)
    );

    // ========================================
    // queue decision and occupancy
    // ========================================
    queued_count u_qcnt (
        .hold       (hold),
        .debug_on   (debug_on),
        .slot_v     (slot_v),
        .slot_brk   (slot_brk),
        .slot_jc    (slot_jc),
        .slot_ret   (slot_ret),
        .slot_tb    (slot_tb),
        .iq_free    (iq_free),
        .rob_free   (rob_free),
        .queued_cnt (dispatch_cnt),
        .queued_onp (dispatch_onp)
    );

    // both rings take the same allocation each cycle
    entry_ring #(.entries(dispatch_pkg::iq_entries)) iq_ring (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc        (dispatch_cnt),
        .head_release (iq_release),
        .free         (iq_free)
    );

    entry_ring #(.entries(dispatch_pkg::rob_entries)) rob_ring (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc        (dispatch_cnt),
        .head_release (rob_release),
        .free         (rob_free)
    );

endmodule

// ==== hdl/entry_ring.sv ====
/* circular occupancy tracker: tail allocation, head release, flush */
`timescale 1ns/1ns

module entry_ring #(
    parameter int entries = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  dispatch_pkg::cnt_t       alloc,
    input  logic                     head_release,
    output logic [$clog2(entries):0] free
);

    // pointers carry one wrap bit above the index
    typedef logic [$clog2(entries):0] ptr_t;

    // oldest occupied entry
    ptr_t head;
    // next entry to allocate
    ptr_t tail;
    // entries in use
    ptr_t occ;

    // ========================================
    // occupancy
    // ========================================
    // wrap bit keeps full and empty apart, entries must be a power of two
    assign occ = tail - head;
    assign free = ptr_t'(entries) - occ;

    // ========================================
    // pointer update
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // branch miss drops every entry at once
            head <= '0;
            tail <= '0;
        end else begin
            // several entries may be taken in one cycle
            tail <= tail + ptr_t'(alloc);
            // one entry leaves per pulse, pulses on an empty ring are lost
            if (head_release && occ != '0) begin
                head <= head + ptr_t'(1);
            end
        end
    end

    // ========================================
    // checks
    // ========================================
    // queue count must never hand out more entries than are free
    a_alloc_fits: assert property (
        @(posedge clk) disable iff (rst)
        ptr_t'(alloc) <= free
    ) else $error("entry_ring: alloc %0d above free %0d", alloc, free);

endmodule

// ==== hdl/fetch_ctrl.sv ====
/* fetch FSM: wishbone bundle read, bundle hold, retire of queued slots
   and branch-miss flush sequencing */
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    output dispatch_pkg::wb_req_t    wb_req,
    input  dispatch_pkg::wb_rsp_t    wb_rsp,
    input  logic                     branch_miss,
    input  dispatch_pkg::adr_t       redirect_adr,
    input  dispatch_pkg::slot_mask_t queued_onp,
    input  logic                     timer_done,
    output logic                     hold,
    output logic                     flush,
    output logic                     timer_start,
    output dispatch_pkg::slot_mask_t slot_v,
    output dispatch_pkg::slot_mask_t slot_brk,
    output dispatch_pkg::slot_mask_t slot_jc,
    output dispatch_pkg::slot_mask_t slot_ret,
    output dispatch_pkg::slot_mask_t slot_tb
);

    dispatch_pkg::fetch_state_t state;
    dispatch_pkg::bundle_t bundle;
    // program address of the current bundle
    dispatch_pkg::adr_t pc;
    // restart address from the last miss
    dispatch_pkg::adr_t redirect;
    logic cyc;
    // miss seen while a read was still open
    logic miss_pend;
    logic open_fetch;
    logic enter_flush;
    // slots left after this cycle's dispatch
    dispatch_pkg::slot_mask_t remain;

    // ========================================
    // control decode
    // ========================================
    assign open_fetch = cyc && !wb_rsp.ack;
    // an open read finishes first and its word is dropped
    assign enter_flush = (state != dispatch_pkg::flush) &&
                         ((branch_miss && !open_fetch) || (miss_pend && wb_rsp.ack));
    assign timer_start = enter_flush;
    assign flush = branch_miss;
    assign hold = (state != dispatch_pkg::dispatch);
    assign remain = slot_v & ~queued_onp;

    // classic read, stb always travels with cyc
    assign wb_req.cyc = cyc;
    assign wb_req.stb = cyc;
    assign wb_req.adr = pc;

    // per-slot vectors for the queue count
    always_comb begin
        for (int i = 0; i < dispatch_pkg::slots; i++) begin
            slot_v[i] = bundle.slot[i].valid;
            slot_brk[i] = bundle.slot[i].brk;
            slot_jc[i] = bundle.slot[i].jc;
            slot_ret[i] = bundle.slot[i].ret;
            slot_tb[i] = bundle.slot[i].take_branch;
        end
    end

    // ========================================
    // state machine
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dispatch_pkg::idle;
            cyc <= 1'b0;
            miss_pend <= 1'b0;
            pc <= '0;
        end else begin
            miss_pend <= (miss_pend || (branch_miss && open_fetch)) && !wb_rsp.ack;
            case (state)
                dispatch_pkg::idle: state <= dispatch_pkg::fetch;
                dispatch_pkg::fetch: begin
                    // request goes out one cycle after entry
                    if (!cyc) begin
                        cyc <= 1'b1;
                    end else if (wb_rsp.ack) begin
                        cyc <= 1'b0;
                        state <= dispatch_pkg::dispatch;
                    end
                end
                dispatch_pkg::dispatch: begin
                    if (remain == '0) begin
                        state <= dispatch_pkg::fetch;
                        pc <= pc + dispatch_pkg::adr_t'(1);
                    end
                end
                dispatch_pkg::flush: begin
                    if (timer_done) begin
                        state <= dispatch_pkg::fetch;
                        pc <= branch_miss ? redirect_adr : redirect;
                    end
                end
                default: state <= dispatch_pkg::idle;
            endcase
            // miss overrides whatever the state chose
            if (enter_flush) begin
                state <= dispatch_pkg::flush;
                cyc <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (branch_miss) begin
            redirect <= redirect_adr;
        end
    end

    // ========================================
    // bundle hold
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || branch_miss) begin
            for (int i = 0; i < dispatch_pkg::slots; i++) begin
                bundle.slot[i].valid <= 1'b0;
            end
        end else if (state == dispatch_pkg::fetch && cyc && wb_rsp.ack && !miss_pend) begin
            bundle <= dispatch_pkg::bundle_t'(wb_rsp.dat);
        end else if (state == dispatch_pkg::dispatch) begin
            // queued slots retire from the held copy
            for (int i = 0; i < dispatch_pkg::slots; i++) begin
                if (queued_onp[i]) begin
                    bundle.slot[i].valid <= 1'b0;
                end
            end
        end
    end

    // ========================================
    // checks
    // ========================================
    a_stb_cyc: assert property (
        @(posedge clk) disable iff (rst)
        wb_req.stb |-> wb_req.cyc
    ) else $error("fetch_ctrl: stb without cyc");

    // an unacked strobe stays up on the same address
    a_stb_hold: assert property (
        @(posedge clk) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr)
    ) else $error("fetch_ctrl: request dropped or moved before ack");

endmodule

// ==== hdl/flush_timer.sv ====
/* branch-miss recovery down-counter with end-of-window pulse */
`timescale 1ns/1ns

module flush_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    // cycles left in the window, zero when idle
    dispatch_pkg::flush_cnt_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= dispatch_pkg::flush_cnt_t'(dispatch_pkg::flush_cycles);
        end else if (count != '0) begin
            count <= count - dispatch_pkg::flush_cnt_t'(1);
        end
    end

    // last cycle of the window, the count hits zero at its closing edge
    assign done = (count == dispatch_pkg::flush_cnt_t'(1));

    // fetch may only open a new window once the last one closed
    a_no_restart: assert property (
        @(posedge clk) disable iff (rst)
        start |-> count == '0
    ) else $error("flush_timer: start while counting");

endmodule

// ==== hdl/queued_count.sv ====
/* combinational count of bundle slots that can queue this cycle,
   with the mask of the slots chosen */
`timescale 1ns/1ns

module queued_count (
    input  logic                     hold,
    input  logic                     debug_on,
    input  dispatch_pkg::slot_mask_t slot_v,
    input  dispatch_pkg::slot_mask_t slot_brk,
    input  dispatch_pkg::slot_mask_t slot_jc,
    input  dispatch_pkg::slot_mask_t slot_ret,
    input  dispatch_pkg::slot_mask_t slot_tb,
    input  dispatch_pkg::iq_free_t   iq_free,
    input  dispatch_pkg::rob_free_t  rob_free,
    output dispatch_pkg::cnt_t       queued_cnt,
    output dispatch_pkg::slot_mask_t queued_onp
);

    // lowest set bit of the valid mask
    dispatch_pkg::slot_mask_t low_bit;
    // valid bits form one run with no holes
    logic contig;

    // ========================================
    // valid pattern check
    // ========================================
    assign low_bit = slot_v & (~slot_v + dispatch_pkg::slot_mask_t'(1));
    // adding the lowest bit carries through a single run and clears it
    assign contig = ((slot_v + low_bit) & slot_v) == '0;

    // ========================================
    // slot selection
    // ========================================
    always_comb begin
        dispatch_pkg::cnt_t n;
        logic stop;
        logic may_add;
        n = '0;
        stop = 1'b0;
        may_add = 1'b0;
        queued_onp = '0;
        // nothing queues while fetch holds or on a broken pattern
        if (!hold && contig) begin
            for (int i = 0; i < dispatch_pkg::slots; i++) begin
                if (slot_v[i] && !stop) begin
                    // first candidate always tries, later ones need ways and no single-step
                    may_add = (n == '0) ||
                              (!debug_on && n < dispatch_pkg::cnt_t'(dispatch_pkg::ways));
                    // a free entry is needed in both the issue queue and the rob
                    if (may_add &&
                        iq_free > dispatch_pkg::iq_free_t'(n) &&
                        rob_free > dispatch_pkg::rob_free_t'(n)) begin
                        queued_onp[i] = 1'b1;
                        n = n + dispatch_pkg::cnt_t'(1);
                        // flow change ends the group for this cycle
                        stop = slot_brk[i] | slot_jc[i] | slot_ret[i] | slot_tb[i];
                    end else begin
                        stop = 1'b1;
                    end
                end
            end
        end
        queued_cnt = n;
    end

    // ========================================
    // checks
    // ========================================
    // fetch retires slots lowest first, so a hole means a malformed bundle
    always_comb begin
        if (!hold) begin
            a_contig: assert (contig)
            else $error("queued_count: non-contiguous slot_v %b", slot_v);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build and run the dispatch testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_dispatch \
    -o sim_dispatch 2>&1 | tee build.log \
    && ./obj_dir/sim_dispatch 2>&1 | tee sim.log

grep -q "^TEST OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verif/dispatch_testdata.txt ====
// header: bundle count, release start cycle, debug start cycle, miss cycle, redirect adr
// then per line: bundle word (slot 0 in low byte) and its total queued slot count
0e 64 fa 190 2
83828180 4
00828180 3
87868584 4
80a08180 4
8090c080 4
00008881 2
00000000 0
0000c1c0 2
81828384 4
000000a5 1
84838281 4
00908180 3
88888888 4
00000080 1

// ==== verif/tb_dispatch.sv ====
/* dispatch stage testbench: clock, reset, wishbone slave memory,
   reference model of rings and held bundle, checks and watchdog */
`timescale 1ns/1ns

module tb_dispatch;

    logic clk = 1'b0;
    logic rst;
    dispatch_pkg::wb_req_t wb_req;
    dispatch_pkg::wb_rsp_t wb_rsp;
    logic branch_miss;
    dispatch_pkg::adr_t redirect_adr;
    logic iq_release;
    logic rob_release;
    logic debug_on;
    dispatch_pkg::cnt_t dispatch_cnt;
    dispatch_pkg::slot_mask_t dispatch_onp;

    // header words, then one bundle word and its slot count per line
    logic [31:0] tdata [0:63];
    int n_bundles, rel_start, dbg_start, miss_cycle;
    logic [31:0] rng;
    int errors, cycle, wait_left, miss_at, lim;
    // model of ring occupancy and the held bundle
    int iq_occ, rob_occ, bundle_total, bundle_exp;
    logic [31:0] mword;
    dispatch_pkg::slot_mask_t mmask, exp_onp;
    dispatch_pkg::cnt_t exp_cnt;
    logic drop, load, prev_cyc, seen_req, miss_seen, redirected, bundle_active;
    // last redirected fetch ran past the file
    logic finished;

    always #10 clk = ~clk;

    dispatch_top DUT (
        .clk          (clk),
        .rst          (rst),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .branch_miss  (branch_miss),
        .redirect_adr (redirect_adr),
        .iq_release   (iq_release),
        .rob_release  (rob_release),
        .debug_on     (debug_on),
        .dispatch_cnt (dispatch_cnt),
        .dispatch_onp (dispatch_onp)
    );

    // ========================================
    // helpers
    // ========================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // beyond the file the slave returns bundles with no valid slot
    function automatic logic [31:0] word_at(input dispatch_pkg::adr_t a);
        if (int'(a) < n_bundles) return tdata[5 + 2 * int'(a)];
        return {a, a} & 32'h7f7f_7f7f;
    endfunction

    function automatic int count_at(input dispatch_pkg::adr_t a);
        if (int'(a) < n_bundles) return int'(tdata[6 + 2 * int'(a)]);
        return 0;
    endfunction

    function automatic dispatch_pkg::cnt_t ones(input dispatch_pkg::slot_mask_t m);
        dispatch_pkg::cnt_t c;
        c = '0;
        for (int i = 0; i < 4; i++) c = c + dispatch_pkg::cnt_t'(m[i]);
        return c;
    endfunction

    // lowest first, stop after a flow change, need room in both rings
    function automatic dispatch_pkg::slot_mask_t pick_slots(input logic [31:0] w,
            input dispatch_pkg::slot_mask_t m, input int iqf, input int robf,
            input logic dbg);
        dispatch_pkg::slot_mask_t onp;
        int n;
        logic stop;
        onp = '0;
        n = 0;
        stop = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (m[i] && !stop) begin
                if ((n == 0 || (!dbg && n < 3)) && iqf > n && robf > n) begin
                    onp[i] = 1'b1;
                    n++;
                    // brk, jc, ret, taken branch
                    stop = |w[8*i+3 +: 4];
                end else begin
                    stop = 1'b1;
                end
            end
        end
        return onp;
    endfunction

    task automatic end_run;
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    // ========================================
    // watchdog
    // ========================================
    initial begin
        #1;
        lim = (n_bundles + 5) * 200 + 1000;
        repeat (lim) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", lim);
        $display("TEST FAILED");
        $finish;
    end

    // ========================================
    // stimulus, slave and checks
    // ========================================
    initial begin
        $readmemh("verif/dispatch_testdata.txt", tdata);
        n_bundles = int'(tdata[0]);
        rel_start = int'(tdata[1]);
        dbg_start = int'(tdata[2]);
        miss_cycle = int'(tdata[3]);
        redirect_adr = dispatch_pkg::adr_t'(tdata[4]);
        rst = 1'b1;
        wb_rsp = '0;
        branch_miss = 1'b0;
        iq_release = 1'b0;
        rob_release = 1'b0;
        debug_on = 1'b0;
        rng = 32'h1a1d_0373;
        errors = 0;
        cycle = 0;
        wait_left = 0;
        iq_occ = 0;
        rob_occ = 0;
        mword = '0;
        mmask = '0;
        drop = 1'b0;
        prev_cyc = 1'b0;
        seen_req = 1'b0;
        miss_seen = 1'b0;
        redirected = 1'b0;
        bundle_active = 1'b0;
        bundle_total = 0;
        bundle_exp = 0;
        finished = 1'b0;
        repeat (16) begin
            @(negedge clk);
            if (wb_req.cyc || wb_req.stb) begin
                errors++;
                $display("bus request raised during reset");
            end
        end
        rst = 1'b0;
        while (!finished) begin
            @(negedge clk);
            cycle++;
            // new request on the bus
            if (wb_req.cyc && !prev_cyc) begin
                if (!seen_req && wb_req.adr !== '0) begin
                    errors++;
                    $display("FAIL wb_req.adr got %h exp %h", wb_req.adr, 16'h0);
                end
                seen_req = 1'b1;
                if (miss_seen && !redirected) begin
                    redirected = 1'b1;
                    if (wb_req.adr !== redirect_adr) begin
                        errors++;
                        $display("FAIL wb_req.adr got %h exp %h", wb_req.adr, redirect_adr);
                    end
                    if (cycle - miss_at < dispatch_pkg::flush_cycles + 1) begin
                        errors++;
                        $display("fetch restarted before the recovery window ended");
                    end
                end
                if (redirected && int'(wb_req.adr) >= n_bundles) finished = 1'b1;
            end
            prev_cyc = wb_req.cyc;
            // slave with 0 to 3 wait states, answers only a strobed cycle
            load = 1'b0;
            if (wb_rsp.ack) begin
                wb_rsp.ack = 1'b0;
                rng = lcg_next(rng);
                wait_left = int'(rng[17:16]);
            end else if (wb_req.cyc && wb_req.stb) begin
                if (wait_left == 0) begin
                    wb_rsp.ack = 1'b1;
                    wb_rsp.dat = word_at(wb_req.adr);
                    load = 1'b1;
                end else begin
                    wait_left--;
                end
            end
            branch_miss = (cycle == miss_cycle);
            // single-step stays on through the redirected refetch
            debug_on = (cycle >= dbg_start);
            if (cycle >= rel_start) begin
                rng = lcg_next(rng);
                iq_release = rng[20];
                rob_release = rng[23];
            end
            // miss during an open read drops the word that comes back
            if (branch_miss && wb_req.cyc && !wb_rsp.ack) drop = 1'b1;
            if (branch_miss) begin
                miss_seen = 1'b1;
                miss_at = cycle;
            end
            #1;
            exp_onp = pick_slots(mword, mmask, dispatch_pkg::iq_entries - iq_occ,
                                 dispatch_pkg::rob_entries - rob_occ, debug_on);
            exp_cnt = ones(exp_onp);
            if (dispatch_cnt !== exp_cnt) begin
                errors++;
                $display("FAIL dispatch_cnt got %h exp %h", dispatch_cnt, exp_cnt);
            end
            if (dispatch_onp !== exp_onp) begin
                errors++;
                $display("FAIL dispatch_onp got %h exp %h", dispatch_onp, exp_onp);
            end
            if (ones(dispatch_onp) !== dispatch_cnt) begin
                errors++;
                $display("slot mask and slot count disagree");
            end
            if (debug_on && dispatch_cnt > 1) begin
                errors++;
                $display("more than one slot queued in single-step mode");
            end
            // a release on an empty model ring is lost
            iq_occ = iq_occ + int'(exp_cnt) - int'(iq_release && iq_occ > 0);
            rob_occ = rob_occ + int'(exp_cnt) - int'(rob_release && rob_occ > 0);
            bundle_total += int'(dispatch_cnt);
            mmask = mmask & ~exp_onp;
            if (bundle_active && mmask == '0) begin
                bundle_active = 1'b0;
                if (bundle_total != bundle_exp) begin
                    errors++;
                    $display("FAIL bundle_total got %h exp %h", bundle_total, bundle_exp);
                end
            end
            if (load) begin
                if (!drop && !branch_miss) begin
                    mword = wb_rsp.dat;
                    mmask = {wb_rsp.dat[31], wb_rsp.dat[23], wb_rsp.dat[15], wb_rsp.dat[7]};
                    bundle_exp = count_at(wb_req.adr);
                    bundle_total = 0;
                    bundle_active = 1'b1;
                end
                drop = 1'b0;
            end
            if (branch_miss) begin
                iq_occ = 0;
                rob_occ = 0;
                mmask = '0;
                bundle_active = 1'b0;
            end
        end
        end_run();
    end

endmodule
